// ==== control_pipe.sv ====
`default_nettype none

module control_pipe import rv32i_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  ctrl_word_t new_word,
    input  logic       load_use,
    input  logic       ex_load_pc,
    input  logic       i_resp,
    input  logic       d_resp,
    output ctrl_word_t if_id,
    output ctrl_word_t id_ex,
    output ctrl_word_t ex_mem,
    output ctrl_word_t mem_wb,
    output logic       stall_all,
    output logic       stall_decode
);

    logic d_ready;
    logic d_ready_next;
    logic mem_access;

    assign mem_access = ex_mem.d_read | ex_mem.d_write;

    // A response seen during an instruction-side stall is remembered
    always_comb begin
        if (!mem_access || d_resp) begin
            d_ready_next = 1'b1;
        end else begin
            d_ready_next = d_ready;
        end
    end

    assign stall_all    = !i_resp || !d_ready_next;
    assign stall_decode = load_use;

    always_ff @(posedge clk) begin
        if (rst) begin
            if_id   <= ctrl_bubble;
            id_ex   <= ctrl_bubble;
            ex_mem  <= ctrl_bubble;
            mem_wb  <= ctrl_bubble;
            d_ready <= 1'b0;
        end else if (stall_all) begin
            // Whole pipe frozen
            d_ready <= d_ready_next;
        end else begin
            d_ready <= 1'b0;

            // A redirect kills the wrong-path word even if decode was held
            if (ex_load_pc) begin
                if_id <= ctrl_bubble;
            end else if (!load_use) begin
                if_id <= new_word;
            end

            if (ex_load_pc || load_use) begin
                id_ex <= ctrl_bubble;
            end else begin
                id_ex <= if_id;
            end

            ex_mem <= id_ex;
            mem_wb <= ex_mem;
        end
    end

endmodule

`default_nettype wire

// ==== control_rom.sv ====
`default_nettype none

module control_rom import rv32i_pkg::*; (
    input  rv32i_instr_u instruction,
    output ctrl_word_t   ctrl
);

    logic [2:0] funct3;
    logic       alt_op;

    assign funct3 = instruction.r.funct3;

    // funct7[5] in R-type, imm[10] for I-type shifts; addi never subtracts
    assign alt_op = (instruction.r.opcode == op_reg) ? instruction.r.funct7[5] :
                    (funct3 == 3'b101) ? instruction.i.imm12[10] : 1'b0;

    function automatic alu_ops_t arith_op(input logic [2:0] f3, input logic alt);
        alu_ops_t op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            3'b111:  op = alu_and;
            default: op = alu_add;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl        = ctrl_bubble;
        ctrl.opcode = rv32i_opcode_t'(instruction.r.opcode);
        ctrl.rs1    = instruction.r.rs1;
        ctrl.rs2    = instruction.r.rs2;
        ctrl.rd     = instruction.r.rd;
        case (instruction.r.opcode)
            op_lui: begin
                ctrl.rs1           = '0;
                ctrl.rs2           = '0;
                ctrl.wbdatamux_sel = wb_u_imm;
            end
            op_auipc: begin
                ctrl.rs1           = '0;
                ctrl.rs2           = '0;
                ctrl.alumux1_sel   = alumux1_pc;
                ctrl.alumux2_sel   = alumux2_u_imm;
                ctrl.wbdatamux_sel = wb_alu_out;
            end
            op_jal: begin
                ctrl.rs1           = '0;
                ctrl.rs2           = '0;
                ctrl.alumux1_sel   = alumux1_pc;
                ctrl.alumux2_sel   = alumux2_j_imm;
                ctrl.pcmux_sel     = pcmux_alu_out;
                ctrl.wbdatamux_sel = wb_pc_plus4;
            end
            op_jalr: begin
                // Only funct3 000 is a legal jalr
                if (instruction.i.funct3 != 3'b000) begin
                    ctrl = ctrl_bubble;
                end else begin
                    ctrl.rs1           = instruction.i.rs1;
                    ctrl.rs2           = '0;
                    ctrl.rd            = instruction.i.rd;
                    ctrl.pcmux_sel     = pcmux_alu_mod2;
                    ctrl.wbdatamux_sel = wb_pc_plus4;
                end
            end
            op_br: begin
                ctrl.rd          = '0;
                ctrl.alumux1_sel = alumux1_pc;
                ctrl.alumux2_sel = alumux2_b_imm;
                ctrl.cmpop       = branch_funct3_t'(funct3);
                ctrl.pcmux_sel   = pcmux_alu_out;
            end
            op_load: begin
                ctrl.rs2    = '0;
                ctrl.d_read = 1'b1;
                case (funct3)
                    3'b000:  ctrl.wbdatamux_sel = wb_lb;
                    3'b001:  ctrl.wbdatamux_sel = wb_lh;
                    3'b010:  ctrl.wbdatamux_sel = wb_lw;
                    3'b100:  ctrl.wbdatamux_sel = wb_lbu;
                    3'b101:  ctrl.wbdatamux_sel = wb_lhu;
                    default: ctrl = ctrl_bubble;
                endcase
            end
            op_store: begin
                ctrl.rd          = '0;
                ctrl.alumux2_sel = alumux2_s_imm;
                ctrl.d_write     = 1'b1;
                // Lane alignment by address happens in the datapath
                case (funct3)
                    3'b000:  ctrl.d_byte_enable = 4'b0001;
                    3'b001:  ctrl.d_byte_enable = 4'b0011;
                    3'b010:  ctrl.d_byte_enable = 4'b1111;
                    default: ctrl = ctrl_bubble;
                endcase
            end
            op_imm, op_reg: begin
                if (instruction.r.opcode == op_imm) begin
                    ctrl.rs1         = instruction.i.rs1;
                    ctrl.rs2         = '0;
                    ctrl.cmpmux2_sel = cmpmux2_i_imm;
                end else begin
                    ctrl.alumux2_sel = alumux2_rs2;
                end
                ctrl.aluop         = arith_op(funct3, alt_op);
                ctrl.wbdatamux_sel = wb_alu_out;
                // Set-less-than goes through the comparator
                if (funct3 == 3'b010 || funct3 == 3'b011) begin
                    ctrl.cmpop         = funct3[0] ? bltu : blt;
                    ctrl.wbdatamux_sel = wb_br_en;
                end
            end
            default: ctrl = ctrl_bubble;
        endcase
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rv32i_pkg.sv
control_rom.sv
hazard_unit.sv
control_pipe.sv
pipeline_control.sv
tb_checker.sv
tb_pipeline_control.sv

// ==== hazard_unit.sv ====
`default_nettype none

module hazard_unit import rv32i_pkg::*; (
    input  ctrl_word_t if_id,
    input  ctrl_word_t id_ex,
    input  ctrl_word_t ex_mem,
    input  ctrl_word_t mem_wb,
    output fwd_t       fwd
);

    logic rs1_load_use;
    logic rs2_load_use;

    // Youngest matching producer wins; x0 is never forwarded
    function automatic rsmux_sel_t pick_source(
        input  rv32i_reg   src,
        input  ctrl_word_t ex_word,
        input  ctrl_word_t mem_word,
        input  ctrl_word_t wb_word,
        output logic       load_use
    );
        rsmux_sel_t sel;
        sel      = rsmux_regfile_out;
        load_use = 1'b0;
        if (src != '0) begin
            if (ex_word.rd == src) begin
                if (ex_word.wbdatamux_sel[3]) begin
                    // Load data not ready yet, decode waits a cycle
                    load_use = 1'b1;
                end else begin
                    sel = rsmux_sel_t'(ex_word.wbdatamux_sel[2:0]);
                end
            end else if (mem_word.rd == src) begin
                sel = rsmux_wbdatamux_out;
            end else if (wb_word.rd == src) begin
                sel = rsmux_wbdata_out;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwd.rs1mux_sel = pick_source(if_id.rs1, id_ex, ex_mem, mem_wb, rs1_load_use);
        fwd.rs2mux_sel = pick_source(if_id.rs2, id_ex, ex_mem, mem_wb, rs2_load_use);
        fwd.load_use   = rs1_load_use | rs2_load_use;
    end

endmodule

`default_nettype wire

// ==== pipeline_control.sv ====
`default_nettype none

module pipeline_control import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  rv32i_word instruction,
    input  logic      i_resp,
    input  logic      d_resp,
    input  logic      ex_load_pc,
    output id_sel_t   id_sel,
    output ex_ctrl_t  ex_ctrl,
    output mem_ctrl_t mem_ctrl,
    output rv32i_reg  regfile_rd,
    output stall_t    stall
);

    rv32i_instr_u instr;
    ctrl_word_t   new_word;
    ctrl_word_t   if_id;
    ctrl_word_t   id_ex;
    ctrl_word_t   ex_mem;
    ctrl_word_t   mem_wb;
    fwd_t         fwd;
    logic         stall_all;
    logic         stall_decode;

    assign instr = instruction;

    control_rom control_rom_inst (
        .instruction (instr),
        .ctrl        (new_word)
    );

    hazard_unit hazard_unit_inst (
        .if_id  (if_id),
        .id_ex  (id_ex),
        .ex_mem (ex_mem),
        .mem_wb (mem_wb),
        .fwd    (fwd)
    );

    control_pipe control_pipe_inst (
        .clk          (clk),
        .rst          (rst),
        .new_word     (new_word),
        .load_use     (fwd.load_use),
        .ex_load_pc   (ex_load_pc),
        .i_resp       (i_resp),
        .d_resp       (d_resp),
        .if_id        (if_id),
        .id_ex        (id_ex),
        .ex_mem       (ex_mem),
        .mem_wb       (mem_wb),
        .stall_all    (stall_all),
        .stall_decode (stall_decode)
    );

    // Each stage takes its selects from its own register
    always_comb begin
        id_sel.alumux1_sel = if_id.alumux1_sel;
        id_sel.alumux2_sel = if_id.alumux2_sel;
        id_sel.cmpmux2_sel = if_id.cmpmux2_sel;
        id_sel.rs1mux_sel  = fwd.rs1mux_sel;
        id_sel.rs2mux_sel  = fwd.rs2mux_sel;

        ex_ctrl.aluop     = id_ex.aluop;
        ex_ctrl.cmpop     = id_ex.cmpop;
        ex_ctrl.pcmux_sel = id_ex.pcmux_sel;

        mem_ctrl.wbdatamux_sel = ex_mem.wbdatamux_sel;
        mem_ctrl.d_read        = ex_mem.d_read;
        mem_ctrl.d_write       = ex_mem.d_write;
        mem_ctrl.d_byte_enable = ex_mem.d_byte_enable;

        regfile_rd = mem_wb.rd;
    end

    // Decode also holds for a load-use bubble
    assign stall.id  = stall_all | stall_decode;
    assign stall.ex  = stall_all;
    assign stall.mem = stall_all;
    assign stall.wb  = stall_all;

endmodule

`default_nettype wire

// ==== rv32i_pkg.sv ====
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] rv32i_word;
    typedef logic [4:0]  rv32i_reg;

    // Major opcode classes, op_none marks a bubble
    typedef enum logic [6:0] {
        op_none  = 7'b0000000,
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    typedef enum logic [2:0] {
        alu_add = 3'b000,
        alu_sll = 3'b001,
        alu_sra = 3'b010,
        alu_sub = 3'b011,
        alu_xor = 3'b100,
        alu_srl = 3'b101,
        alu_or  = 3'b110,
        alu_and = 3'b111
    } alu_ops_t;

    // Same codes as funct3 of the branch instructions
    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic {
        alumux1_rs1 = 1'b0,
        alumux1_pc  = 1'b1
    } alumux1_sel_t;

    typedef enum logic [2:0] {
        alumux2_i_imm = 3'b000,
        alumux2_u_imm = 3'b001,
        alumux2_b_imm = 3'b010,
        alumux2_s_imm = 3'b011,
        alumux2_j_imm = 3'b100,
        alumux2_rs2   = 3'b101
    } alumux2_sel_t;

    typedef enum logic {
        cmpmux2_rs2   = 1'b0,
        cmpmux2_i_imm = 1'b1
    } cmpmux2_sel_t;

    typedef enum logic [1:0] {
        pcmux_pc_plus4 = 2'b00,
        pcmux_alu_out  = 2'b01,
        pcmux_alu_mod2 = 2'b10
    } pcmux_sel_t;

    // Operand source in decode
    typedef enum logic [2:0] {
        rsmux_regfile_out   = 3'b000,
        rsmux_alu_out       = 3'b001,
        rsmux_br_en         = 3'b010,
        rsmux_u_imm         = 3'b011,
        rsmux_pc_plus4      = 3'b100,
        rsmux_wbdatamux_out = 3'b101,
        rsmux_wbdata_out    = 3'b110
    } rsmux_sel_t;

    // Bit 3 marks a load; otherwise the low bits reuse the rsmux codes
    typedef enum logic [3:0] {
        wb_none     = 4'b0000,
        wb_alu_out  = 4'b0001,
        wb_br_en    = 4'b0010,
        wb_u_imm    = 4'b0011,
        wb_pc_plus4 = 4'b0100,
        wb_lw       = 4'b1000,
        wb_lh       = 4'b1001,
        wb_lhu      = 4'b1010,
        wb_lb       = 4'b1011,
        wb_lbu      = 4'b1100
    } wbdatamux_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        rv32i_reg   rs2;
        rv32i_reg   rs1;
        logic [2:0] funct3;
        rv32i_reg   rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        rv32i_reg    rs1;
        logic [2:0]  funct3;
        rv32i_reg    rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } rv32i_instr_u;

    typedef struct packed {
        rv32i_opcode_t  opcode;
        alumux1_sel_t   alumux1_sel;
        alumux2_sel_t   alumux2_sel;
        cmpmux2_sel_t   cmpmux2_sel;
        alu_ops_t       aluop;
        branch_funct3_t cmpop;
        pcmux_sel_t     pcmux_sel;
        wbdatamux_sel_t wbdatamux_sel;
        logic           d_read;
        logic           d_write;
        logic [3:0]     d_byte_enable;
        rv32i_reg       rs1;
        rv32i_reg       rs2;
        rv32i_reg       rd;
    } ctrl_word_t;

    // No memory access, no writeback, PC advances normally
    localparam ctrl_word_t ctrl_bubble = '{
        opcode:        op_none,
        alumux1_sel:   alumux1_rs1,
        alumux2_sel:   alumux2_i_imm,
        cmpmux2_sel:   cmpmux2_rs2,
        aluop:         alu_add,
        cmpop:         beq,
        pcmux_sel:     pcmux_pc_plus4,
        wbdatamux_sel: wb_none,
        d_read:        1'b0,
        d_write:       1'b0,
        d_byte_enable: 4'b0000,
        rs1:           5'd0,
        rs2:           5'd0,
        rd:            5'd0
    };

    typedef struct packed {
        alumux1_sel_t alumux1_sel;
        alumux2_sel_t alumux2_sel;
        cmpmux2_sel_t cmpmux2_sel;
        rsmux_sel_t   rs1mux_sel;
        rsmux_sel_t   rs2mux_sel;
    } id_sel_t;

    typedef struct packed {
        alu_ops_t       aluop;
        branch_funct3_t cmpop;
        pcmux_sel_t     pcmux_sel;
    } ex_ctrl_t;

    typedef struct packed {
        wbdatamux_sel_t wbdatamux_sel;
        logic           d_read;
        logic           d_write;
        logic [3:0]     d_byte_enable;
    } mem_ctrl_t;

    typedef struct packed {
        logic id;
        logic ex;
        logic mem;
        logic wb;
    } stall_t;

    typedef struct packed {
        rsmux_sel_t rs1mux_sel;
        rsmux_sel_t rs2mux_sel;
        logic       load_use;
    } fwd_t;

endpackage

`default_nettype wire

// ==== tb_checker.sv ====
`default_nettype none

module tb_checker import rv32i_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  rv32i_word instruction,
    input  logic      i_resp,
    input  logic      d_resp,
    input  logic      ex_load_pc,
    input  id_sel_t   id_sel,
    input  ex_ctrl_t  ex_ctrl,
    input  mem_ctrl_t mem_ctrl,
    input  rv32i_reg  regfile_rd,
    input  stall_t    stall,
    output int        check_count,
    output int        error_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // Reference copies of the four stage registers
    ctrl_word_t m_if_id;
    ctrl_word_t m_id_ex;
    ctrl_word_t m_ex_mem;
    ctrl_word_t m_mem_wb;
    logic       m_d_ready;

    function automatic ctrl_word_t empty_word();
        ctrl_word_t w;
        w = '0;
        w.opcode = op_none;
        w.pcmux_sel = pcmux_pc_plus4;
        return w;
    endfunction

    // Arithmetic op from funct3 and the alt bit
    function automatic alu_ops_t alu_from_funct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            3'b111:  return alu_and;
            default: return alu_add;
        endcase
    endfunction

    // Decode table for the legal encodings that the stimulus produces
    function automatic ctrl_word_t decode_model(input rv32i_word w);
        ctrl_word_t c;
        logic [2:0] f3;
        f3 = w[14:12];
        c = empty_word();
        c.opcode = rv32i_opcode_t'(w[6:0]);
        c.rd = w[11:7];
        c.rs1 = w[19:15];
        c.rs2 = w[24:20];
        case (w[6:0])
            op_lui, op_auipc, op_jal: begin
                c.rs1 = '0;
                c.rs2 = '0;
                c.wbdatamux_sel = (w[6:0] == op_lui) ? wb_u_imm :
                                  (w[6:0] == op_jal) ? wb_pc_plus4 : wb_alu_out;
                if (w[6:0] != op_lui) begin
                    c.alumux1_sel = alumux1_pc;
                    c.alumux2_sel = (w[6:0] == op_jal) ? alumux2_j_imm : alumux2_u_imm;
                end
                if (w[6:0] == op_jal) begin
                    c.pcmux_sel = pcmux_alu_out;
                end
            end
            op_jalr: begin
                c.rs2 = '0;
                c.pcmux_sel = pcmux_alu_mod2;
                c.wbdatamux_sel = wb_pc_plus4;
            end
            op_br: begin
                c.rd = '0;
                c.alumux1_sel = alumux1_pc;
                c.alumux2_sel = alumux2_b_imm;
                c.cmpop = branch_funct3_t'(f3);
                c.pcmux_sel = pcmux_alu_out;
            end
            op_load: begin
                c.rs2 = '0;
                c.d_read = 1'b1;
                c.wbdatamux_sel = (f3 == 3'b000) ? wb_lb :
                                  (f3 == 3'b001) ? wb_lh :
                                  (f3 == 3'b010) ? wb_lw :
                                  (f3 == 3'b100) ? wb_lbu : wb_lhu;
            end
            op_store: begin
                c.rd = '0;
                c.alumux2_sel = alumux2_s_imm;
                c.d_write = 1'b1;
                c.d_byte_enable = (f3 == 3'b000) ? 4'b0001 :
                                  (f3 == 3'b001) ? 4'b0011 : 4'b1111;
            end
            op_imm, op_reg: begin
                if (w[6:0] == op_imm) begin
                    c.rs2 = '0;
                    c.cmpmux2_sel = cmpmux2_i_imm;
                    c.aluop = alu_from_funct3(f3, (f3 == 3'b101) && w[30]);
                end else begin
                    c.alumux2_sel = alumux2_rs2;
                    c.aluop = alu_from_funct3(f3, w[30]);
                end
                c.wbdatamux_sel = wb_alu_out;
                if (f3 == 3'b010 || f3 == 3'b011) begin
                    c.cmpop = f3[0] ? bltu : blt;
                    c.wbdatamux_sel = wb_br_en;
                end
            end
            default: c = empty_word();
        endcase
        return c;
    endfunction

    // Result is {load_use, select}
    function automatic logic [3:0] fwd_source(input rv32i_reg src);
        rsmux_sel_t ex_sel;
        // Operand source named by what the EX instruction writes back
        case (m_id_ex.wbdatamux_sel)
            wb_alu_out:  ex_sel = rsmux_alu_out;
            wb_br_en:    ex_sel = rsmux_br_en;
            wb_u_imm:    ex_sel = rsmux_u_imm;
            wb_pc_plus4: ex_sel = rsmux_pc_plus4;
            default:     ex_sel = rsmux_regfile_out;
        endcase
        if (src == 5'd0) begin
            return {1'b0, rsmux_regfile_out};
        end
        if (m_id_ex.rd == src) begin
            if (m_id_ex.opcode == op_load) begin
                return {1'b1, rsmux_regfile_out};
            end
            return {1'b0, ex_sel};
        end
        if (m_ex_mem.rd == src) begin
            return {1'b0, rsmux_wbdatamux_out};
        end
        if (m_mem_wb.rd == src) begin
            return {1'b0, rsmux_wbdata_out};
        end
        return {1'b0, rsmux_regfile_out};
    endfunction

    function automatic logic data_ready_next();
        return !(m_ex_mem.d_read || m_ex_mem.d_write) || d_resp || m_d_ready;
    endfunction

    task automatic eval_comb(output logic [3:0] rs1_res, output logic [3:0] rs2_res,
                             output logic freeze);
        rs1_res = fwd_source(m_if_id.rs1);
        rs2_res = fwd_source(m_if_id.rs2);
        freeze = !i_resp || !data_ready_next();
    endtask

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("[FAIL] %s expected %h got %h at %0t ns", name, expected, actual, $time);
        end
    endtask

    // Outputs are settled mid-cycle
    always @(negedge clk) begin : compare_outputs
        logic [3:0] rs1_res;
        logic [3:0] rs2_res;
        logic       freeze;
        id_sel_t    exp_id;
        stall_t     exp_stall;
        if (rst) begin
            check_count = 0;
            error_count = 0;
        end else begin
            eval_comb(rs1_res, rs2_res, freeze);
            exp_id.alumux1_sel = m_if_id.alumux1_sel;
            exp_id.alumux2_sel = m_if_id.alumux2_sel;
            exp_id.cmpmux2_sel = m_if_id.cmpmux2_sel;
            exp_id.rs1mux_sel = rsmux_sel_t'(rs1_res[2:0]);
            exp_id.rs2mux_sel = rsmux_sel_t'(rs2_res[2:0]);
            exp_stall.id = freeze | rs1_res[3] | rs2_res[3];
            exp_stall.ex = freeze;
            exp_stall.mem = freeze;
            exp_stall.wb = freeze;
            compare("id_sel", 32'(exp_id), 32'(id_sel));
            compare("ex_ctrl", 32'({m_id_ex.aluop, m_id_ex.cmpop, m_id_ex.pcmux_sel}),
                    32'(ex_ctrl));
            compare("mem_ctrl", 32'({m_ex_mem.wbdatamux_sel, m_ex_mem.d_read,
                    m_ex_mem.d_write, m_ex_mem.d_byte_enable}), 32'(mem_ctrl));
            compare("regfile_rd", 32'(m_mem_wb.rd), 32'(regfile_rd));
            compare("stall", 32'(exp_stall), 32'(stall));
        end
    end

    always @(posedge clk) begin : model_update
        logic [3:0] rs1_res;
        logic [3:0] rs2_res;
        logic       freeze;
        logic       load_use;
        if (rst) begin
            m_if_id = empty_word();
            m_id_ex = empty_word();
            m_ex_mem = empty_word();
            m_mem_wb = empty_word();
            m_d_ready = 1'b0;
        end else begin
            eval_comb(rs1_res, rs2_res, freeze);
            load_use = rs1_res[3] | rs2_res[3];
            if (freeze) begin
                m_d_ready = data_ready_next();
            end else begin
                m_d_ready = 1'b0;
                m_mem_wb = m_ex_mem;
                m_ex_mem = m_id_ex;
                m_id_ex = (ex_load_pc || load_use) ? empty_word() : m_if_id;
                if (ex_load_pc) begin
                    m_if_id = empty_word();
                end else if (!load_use) begin
                    m_if_id = decode_model(instruction);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_pipeline_control.sv ====
`default_nettype none

module tb_pipeline_control import rv32i_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int run_cycles = 3000;
    localparam int clk_period = 40;
    localparam int timeout_ns = (run_cycles + 20) * clk_period + 1000;

    logic      clk = 1'b0;
    logic      rst;
    rv32i_word instruction;
    logic      i_resp;
    logic      d_resp;
    logic      ex_load_pc;
    id_sel_t   id_sel;
    ex_ctrl_t  ex_ctrl;
    mem_ctrl_t mem_ctrl;
    rv32i_reg  regfile_rd;
    stall_t    stall;
    int        check_count;
    int        error_count;

    logic [31:0] lfsr_state = 32'h6bc9_7bfb;

    always #(clk_period / 2) clk = ~clk;

    pipeline_control pipeline_control_inst (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .i_resp      (i_resp),
        .d_resp      (d_resp),
        .ex_load_pc  (ex_load_pc),
        .id_sel      (id_sel),
        .ex_ctrl     (ex_ctrl),
        .mem_ctrl    (mem_ctrl),
        .regfile_rd  (regfile_rd),
        .stall       (stall)
    );

    tb_checker tb_checker_inst (
        .clk         (clk),
        .rst         (rst),
        .instruction (instruction),
        .i_resp      (i_resp),
        .d_resp      (d_resp),
        .ex_load_pc  (ex_load_pc),
        .id_sel      (id_sel),
        .ex_ctrl     (ex_ctrl),
        .mem_ctrl    (mem_ctrl),
        .regfile_rd  (regfile_rd),
        .stall       (stall),
        .check_count (check_count),
        .error_count (error_count)
    );

    // Galois form, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic rv32i_opcode_t pick_opcode(input logic [31:0] idx);
        case (idx)
            0:       return op_lui;
            1:       return op_auipc;
            2:       return op_jal;
            3:       return op_jalr;
            4:       return op_br;
            5:       return op_load;
            6:       return op_store;
            7:       return op_imm;
            default: return op_reg;
        endcase
    endfunction

    // Fold a raw funct3 onto a legal one for the class
    function automatic logic [2:0] legal_funct3(input rv32i_opcode_t op, input logic [2:0] raw);
        case (op)
            op_jalr:  return 3'b000;
            op_br:    return (raw[2:1] == 2'b01) ? {1'b1, raw[1:0]} : raw;
            op_load:  return (raw == 3'd3) ? 3'd2 : (raw == 3'd6) ? 3'd4 :
                             (raw == 3'd7) ? 3'd5 : raw;
            op_store: return (raw[1:0] == 2'b11) ? 3'd2 : {1'b0, raw[1:0]};
            default:  return raw;
        endcase
    endfunction

    task automatic random_instruction(output rv32i_word word);
        logic [31:0]   bits;
        logic [31:0]   regs;
        rv32i_opcode_t op;
        logic [2:0]    f3;
        logic [6:0]    f7;
        take_bits(4, bits);
        op = pick_opcode(bits % 9);
        take_bits(3, bits);
        f3 = legal_funct3(op, bits[2:0]);
        // Registers x0 to x3 only, so hazards are common
        take_bits(6, regs);
        take_bits(1, bits);
        f7 = '0;
        if ((op == op_reg && (f3 == 3'b000 || f3 == 3'b101)) ||
            (op == op_imm && f3 == 3'b101)) begin
            f7[5] = bits[0];
        end
        word = {f7, 3'b000, regs[5:4], 3'b000, regs[3:2], f3, 3'b000, regs[1:0], op};
    endtask

    initial begin : stimulus
        rv32i_word   word;
        logic [31:0] bits;
        int          resp_wait;
        rst = 1'b1;
        instruction = '0;
        i_resp = 1'b1;
        d_resp = 1'b0;
        ex_load_pc = 1'b0;
        resp_wait = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (run_cycles) begin
            @(posedge clk);
            random_instruction(word);
            instruction <= word;
            take_bits(3, bits);
            i_resp <= (bits[2:0] != 3'd0);
            take_bits(7, bits);
            ex_load_pc <= (bits[6:0] < 7'd13);
            // Data memory answers 0 to 3 cycles into a MEM access
            if (d_resp) begin
                d_resp <= 1'b0;
                take_bits(2, bits);
                resp_wait = bits[1:0];
            end else if (mem_ctrl.d_read || mem_ctrl.d_write) begin
                if (resp_wait == 0) begin
                    d_resp <= 1'b1;
                end else begin
                    resp_wait = resp_wait - 1;
                end
            end
        end
        @(posedge clk);
        i_resp <= 1'b1;
        ex_load_pc <= 1'b0;
        d_resp <= 1'b0;
        repeat (4) @(posedge clk);
        #1;
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("test passed");
        end else begin
            if (check_count == 0) begin
                $display("The checker made no comparisons");
            end
            $display("test failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeout_ns);
        $display("Timeout, the stimulus did not finish within %0d ns", timeout_ns);
        $display("test failed");
        $finish;
    end

endmodule

`default_nettype wire
